// ==== logic/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address split is tag | index | offset
`define DC_ADDR_W 32
`define DC_WORD_W 32
`define DC_LINE_W 128

`define DC_OFFSET_W 4
`define DC_INDEX_W 4
`define DC_TAG_W 24

// two ways, one line per way per set
`define DC_NWAY 2

// a line moves over APB as this many word beats
`define DC_BEATS 4

// any nonzero value works
`define DC_LFSR_SEED 16'hace1

`endif

// ==== logic/dcache_pkg.sv ====
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_WORD_W/8-1:0] strb_t;
    typedef logic [`DC_LINE_W-1:0] line_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`DC_NWAY)-1:0] way_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // wstrb of zero is a load
    typedef struct packed {
        logic  valid;
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

    typedef struct packed {
        logic   valid;
        logic   write;
        tag_t   tag;
        index_t index;
        line_t  data;
    } line_cmd_t;

    // be selects data bytes, tag_we writes the entry
    typedef struct packed {
        way_t                   way;
        index_t                 index;
        tag_entry_t             entry;
        line_t                  data;
        logic [`DC_LINE_W/8-1:0] be;
        logic                   tag_we;
    } array_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        EVICT,
        REFILL,
        INSTALL
    } miss_state_e;

endpackage

`default_nettype wire

// ==== logic/dcache_req_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_req_stage
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  cpu_req_t                   cpu_req_i,
    output logic                       req_ready_o,
    output index_t                     rd_index_o,
    input  tag_entry_t [`DC_NWAY-1:0]  tag_rd_i,
    input  line_t [`DC_NWAY-1:0]       data_rd_i,
    input  logic                       miss_done_i,
    input  word_t                      miss_word_i,
    input  logic                       miss_ctrl_busy_i,
    output cpu_req_t                   held_req_o,
    output logic                       miss_o,
    output logic                       store_hit_o,
    output way_t                       hit_way_o,
    output logic                       data_ok_o,
    output word_t                      rdata_o
);

    cpu_req_t held_q;
    logic alive_q;
    logic accept;
    logic is_store;
    logic lookup;
    logic hit;
    tag_t held_tag;
    line_t hit_line;
    logic [`DC_OFFSET_W-3:0] word_sel;

    assign held_tag = held_q.addr[`DC_OFFSET_W+`DC_INDEX_W +: `DC_TAG_W];
    assign word_sel = held_q.addr[`DC_OFFSET_W-1:2];
    assign is_store = held_q.wstrb != '0;

    // arrays answer for held_q this cycle, unless a miss owns them
    assign lookup = held_q.valid && !miss_ctrl_busy_i;

    always_comb begin
        hit = 1'b0;
        hit_way_o = '0;
        hit_line = data_rd_i[0];
        for (int w = 0; w < `DC_NWAY; w++) begin
            if (tag_rd_i[w].valid && tag_rd_i[w].tag == held_tag) begin
                hit = 1'b1;
                hit_way_o = way_t'(w);
                hit_line = data_rd_i[w];
            end
        end
    end

    // a store hit takes the array write port next edge, so hold off one cycle
    assign req_ready_o = alive_q && !miss_ctrl_busy_i &&
                         !(held_q.valid && (!hit || is_store));
    assign accept = cpu_req_i.valid && req_ready_o;

    // read the incoming index at the accepting edge, else keep the held one
    assign rd_index_o = accept ? cpu_req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W]
                               : held_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];

    assign miss_o = lookup && !hit;
    assign store_hit_o = lookup && hit && is_store;
    assign data_ok_o = (lookup && hit) || miss_done_i;
    assign rdata_o = miss_done_i ? miss_word_i
                                 : hit_line[word_sel*`DC_WORD_W +: `DC_WORD_W];
    assign held_req_o = held_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            alive_q <= 1'b0;
            held_q.valid <= 1'b0;
        end else begin
            alive_q <= 1'b1;
            if (accept) begin
                held_q <= cpu_req_i;
            end else if (data_ok_o) begin
                held_q.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_arrays.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_arrays
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  index_t                     rd_index_i,
    input  array_wr_t                  wr_i,
    output tag_entry_t [`DC_NWAY-1:0]  tag_rd_o,
    output line_t [`DC_NWAY-1:0]       data_rd_o
);

    tag_entry_t tag_mem [`DC_NWAY][2**`DC_INDEX_W];
    line_t data_mem [`DC_NWAY][2**`DC_INDEX_W];

    // reset invalidates every line
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DC_NWAY; w++) begin
                for (int s = 0; s < 2**`DC_INDEX_W; s++) begin
                    tag_mem[w][s].valid <= 1'b0;
                end
            end
        end else if (wr_i.tag_we) begin
            tag_mem[wr_i.way][wr_i.index] <= wr_i.entry;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_LINE_W/8; b++) begin
            if (wr_i.be[b]) begin
                data_mem[wr_i.way][wr_i.index][b*8 +: 8] <= wr_i.data[b*8 +: 8];
            end
        end
    end

    // read returns the contents from before a same-edge write
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_NWAY; w++) begin
            tag_rd_o[w] <= tag_mem[w][rd_index_i];
            data_rd_o[w] <= data_mem[w][rd_index_i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       miss_i,
    input  logic                       store_hit_i,
    input  way_t                       hit_way_i,
    input  cpu_req_t                   held_req_i,
    input  tag_entry_t [`DC_NWAY-1:0]  tag_rd_i,
    input  line_t [`DC_NWAY-1:0]       data_rd_i,
    output line_cmd_t                  line_cmd_o,
    input  logic                       line_done_i,
    input  line_t                      line_rdata_i,
    output array_wr_t                  arr_wr_o,
    output logic                       miss_done_o,
    output word_t                      miss_word_o,
    output logic                       busy_o
);

    miss_state_e state_q;
    logic [15:0] lfsr_q;
    way_t pick;
    way_t victim_q;
    line_t fill_q;
    line_cmd_t cmd_q;
    tag_t req_tag;
    index_t req_index;
    logic [`DC_OFFSET_W-3:0] req_word;
    word_t merged_word;
    line_t merged_line;
    logic [`DC_LINE_W/8-1:0] strb_wide;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign req_tag = held_req_i.addr[`DC_OFFSET_W+`DC_INDEX_W +: `DC_TAG_W];
    assign req_index = held_req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_word = held_req_i.addr[`DC_OFFSET_W-1:2];

    // free-running LFSR with taps x^16 + x^14 + x^13 + x^11
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= `DC_LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    assign pick = lfsr_q[$bits(way_t)-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            cmd_q.valid <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (miss_i) begin
                        victim_q <= pick;
                        if (tag_rd_i[pick].valid && tag_rd_i[pick].dirty) begin
                            state_q <= EVICT;
                            cmd_q <= '{valid: 1'b1, write: 1'b1, tag: tag_rd_i[pick].tag,
                                       index: req_index, data: data_rd_i[pick]};
                        end else begin
                            state_q <= REFILL;
                            cmd_q <= '{valid: 1'b1, write: 1'b0, tag: req_tag,
                                       index: req_index, data: '0};
                        end
                    end
                end
                EVICT: begin
                    // victim is out, fetch the missing line next
                    if (line_done_i) begin
                        state_q <= REFILL;
                        cmd_q.write <= 1'b0;
                        cmd_q.tag <= req_tag;
                    end
                end
                REFILL: begin
                    if (line_done_i) begin
                        state_q <= INSTALL;
                        cmd_q.valid <= 1'b0;
                        fill_q <= line_rdata_i;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // loads have no strobes, so this leaves the fetched word as is
    assign merged_word = merge_bytes(fill_q[req_word*`DC_WORD_W +: `DC_WORD_W],
                                     held_req_i.wdata, held_req_i.wstrb);

    always_comb begin
        merged_line = fill_q;
        merged_line[req_word*`DC_WORD_W +: `DC_WORD_W] = merged_word;
    end

    always_comb begin
        strb_wide = '0;
        strb_wide[$bits(strb_t)-1:0] = held_req_i.wstrb;
        arr_wr_o = '0;
        if (state_q == INSTALL) begin
            arr_wr_o.way = victim_q;
            arr_wr_o.index = req_index;
            arr_wr_o.entry = '{valid: 1'b1, dirty: held_req_i.wstrb != '0, tag: req_tag};
            arr_wr_o.data = merged_line;
            arr_wr_o.be = '1;
            arr_wr_o.tag_we = 1'b1;
        end else if (state_q == IDLE && store_hit_i) begin
            arr_wr_o.way = hit_way_i;
            arr_wr_o.index = req_index;
            arr_wr_o.entry = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
            arr_wr_o.data = {`DC_BEATS{held_req_i.wdata}};
            arr_wr_o.be = strb_wide << {req_word, 2'b00};
            arr_wr_o.tag_we = 1'b1;
        end
    end

    assign line_cmd_o = cmd_q;
    assign miss_done_o = state_q == INSTALL;
    assign miss_word_o = merged_word;
    assign busy_o = state_q != IDLE;

endmodule

`default_nettype wire

// ==== logic/dcache_apb_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_apb_master
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  line_cmd_t line_cmd_i,
    output logic      line_done_o,
    output line_t     line_rdata_o,
    output apb_req_t  apb_req_o,
    input  apb_rsp_t  apb_rsp_i
);

    typedef logic [$clog2(`DC_BEATS)-1:0] beat_t;

    localparam beat_t LAST_BEAT = beat_t'(`DC_BEATS - 1);

    // high in the access phase
    logic phase_q;
    beat_t beat_q;
    logic beat_done;
    logic [`DC_LINE_W-`DC_WORD_W-1:0] rbuf_q;

    assign beat_done = line_cmd_i.valid && phase_q && apb_rsp_i.pready;
    assign line_done_o = beat_done && beat_q == LAST_BEAT;

    // last word comes straight off the bus
    assign line_rdata_o = {apb_rsp_i.prdata, rbuf_q};

    always_comb begin
        apb_req_o.psel = line_cmd_i.valid;
        apb_req_o.penable = line_cmd_i.valid && phase_q;
        apb_req_o.pwrite = line_cmd_i.write;
        apb_req_o.paddr = {line_cmd_i.tag, line_cmd_i.index, beat_q, 2'b00};
        apb_req_o.pwdata = line_cmd_i.data[beat_q*`DC_WORD_W +: `DC_WORD_W];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= 1'b0;
            beat_q <= '0;
        end else if (line_cmd_i.valid) begin
            if (!phase_q) begin
                phase_q <= 1'b1;
            end else if (apb_rsp_i.pready) begin
                // back to setup, the counter wraps after the last beat
                phase_q <= 1'b0;
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // read words shift in from the top, beat 0 ends up lowest
    always_ff @(posedge clk) begin
        if (beat_done && !line_cmd_i.write) begin
            rbuf_q <= {apb_rsp_i.prdata, rbuf_q[`DC_LINE_W-`DC_WORD_W-1:`DC_WORD_W]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req_i,
    output logic     req_ready_o,
    output logic     data_ok_o,
    output word_t    rdata_o,
    output apb_req_t apb_req_o,
    input  apb_rsp_t apb_rsp_i
);

    index_t rd_index;
    tag_entry_t [`DC_NWAY-1:0] tag_rd;
    line_t [`DC_NWAY-1:0] data_rd;
    cpu_req_t held_req;
    logic miss;
    logic store_hit;
    way_t hit_way;
    logic miss_done;
    word_t miss_word;
    logic busy;
    array_wr_t arr_wr;
    line_cmd_t line_cmd;
    logic line_done;
    line_t line_rdata;

    dcache_req_stage u_req_stage (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_i        (cpu_req_i),
        .req_ready_o      (req_ready_o),
        .rd_index_o       (rd_index),
        .tag_rd_i         (tag_rd),
        .data_rd_i        (data_rd),
        .miss_done_i      (miss_done),
        .miss_word_i      (miss_word),
        .miss_ctrl_busy_i (busy),
        .held_req_o       (held_req),
        .miss_o           (miss),
        .store_hit_o      (store_hit),
        .hit_way_o        (hit_way),
        .data_ok_o        (data_ok_o),
        .rdata_o          (rdata_o)
    );

    dcache_arrays u_arrays (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_i       (arr_wr),
        .tag_rd_o   (tag_rd),
        .data_rd_o  (data_rd)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .rst          (rst),
        .miss_i       (miss),
        .store_hit_i  (store_hit),
        .hit_way_i    (hit_way),
        .held_req_i   (held_req),
        .tag_rd_i     (tag_rd),
        .data_rd_i    (data_rd),
        .line_cmd_o   (line_cmd),
        .line_done_i  (line_done),
        .line_rdata_i (line_rdata),
        .arr_wr_o     (arr_wr),
        .miss_done_o  (miss_done),
        .miss_word_o  (miss_word),
        .busy_o       (busy)
    );

    dcache_apb_master u_apb_master (
        .clk          (clk),
        .rst          (rst),
        .line_cmd_i   (line_cmd),
        .line_done_o  (line_done),
        .line_rdata_o (line_rdata),
        .apb_req_o    (apb_req_o),
        .apb_rsp_i    (apb_rsp_i)
    );

endmodule

`default_nettype wire

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int MAX_TRACE = 64;
    localparam int WAIT_LIMIT = 2000;

    logic clk;
    logic rst;
    cpu_req_t cpu_req_i = '0;
    logic req_ready_o;
    logic data_ok_o;
    word_t rdata_o;
    apb_req_t apb_req_o;
    apb_rsp_t apb_rsp_i = '0;

    integer seed;
    int errors;
    int timeouts;
    int cyc;
    int n_tr;
    int next_idx;
    int rd_cnt;
    int wr_cnt;
    int beat;
    int wait_cnt;
    bit timed_out;
    addr_t burst_base;

    addr_t t_addr [MAX_TRACE];
    word_t t_wdata [MAX_TRACE];
    strb_t t_strb [MAX_TRACE];
    word_t t_exp [MAX_TRACE];
    logic [7:0] t_kind [MAX_TRACE];

    // one entry per accepted request in acceptance order
    int q_idx [$];
    int q_cyc [$];
    int q_rd [$];
    int q_wr [$];

    // memory behind APB, and the trace's view of memory
    word_t mem [addr_t];
    word_t ref_mem [addr_t];

    // DUT signals captured at the falling edge
    logic s_ready = 1'b0;
    logic s_psel = 1'b0;
    logic s_pen = 1'b0;
    logic s_pready = 1'b0;
    logic s_pwrite = 1'b0;
    addr_t s_paddr = '0;
    word_t s_pwdata = '0;

    dcache_top DUT (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req_i),
        .req_ready_o (req_ready_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .apb_req_o   (apb_req_o),
        .apb_rsp_i   (apb_rsp_i)
    );

    function automatic word_t init_word(addr_t a);
        return {2'b00, a[31:2]} ^ 32'h5a5a0000;
    endfunction

    function automatic word_t mem_read(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return init_word(a);
    endfunction

    function automatic word_t ref_read(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return init_word(a);
    endfunction

    function automatic word_t apply_strobes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic value_error(string name, logic [31:0] expected, logic [31:0] actual);
        errors++;
        $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic plain_error(string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic load_trace();
        integer fd;
        integer cnt;
        reg [8*120-1:0] text;
        reg [15:0] op;
        reg [7:0] kind;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] st;
        logic [31:0] ex;
        n_tr = 0;
        fd = $fopen("sim/dcache_trace.txt", "r");
        if (fd == 0) begin
            plain_error("cannot open sim/dcache_trace.txt");
        end else begin
            while (!$feof(fd) && n_tr < MAX_TRACE) begin
                text = '0;
                cnt = $fgets(text, fd);
                // comment lines fail to give six fields
                cnt = $sscanf(text, "%s %s %h %h %h %h", op, kind, a, wd, st, ex);
                if (cnt == 6) begin
                    t_addr[n_tr] = a;
                    t_wdata[n_tr] = wd;
                    t_strb[n_tr] = st[3:0];
                    t_exp[n_tr] = ex;
                    t_kind[n_tr] = kind;
                    n_tr++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_reset_outputs();
        if (req_ready_o !== 1'b0 || data_ok_o !== 1'b0 ||
            apb_req_o.psel !== 1'b0 || apb_req_o.penable !== 1'b0) begin
            plain_error("control output not low during reset");
        end
    endtask

    // returns at the edge that accepts the request being driven
    task automatic wait_accept();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!s_ready && t < WAIT_LIMIT);
        if (!s_ready) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: req_ready_o never rose for request %0d", next_idx);
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (q_idx.size() > 0 && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (q_idx.size() > 0) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: %0d responses still missing", q_idx.size());
        end
    endtask

    task automatic check_memory();
        foreach (mem[a]) begin
            if (mem[a] !== ref_read(a)) begin
                value_error($sformatf("mem[%h]", a), ref_read(a), mem[a]);
            end
        end
        if (wr_cnt == 0) begin
            plain_error("no line was ever written back");
        end
    endtask

    task automatic end_run();
        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        seed = 32'hfc28742d;
        errors = 0;
        timeouts = 0;
        timed_out = 1'b0;
        rst = 1'b1;
        load_trace();
        @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_tr && !timed_out; i++) begin
            cpu_req_i <= '{valid: 1'b1, addr: t_addr[i], wstrb: t_strb[i], wdata: t_wdata[i]};
            wait_accept();
        end
        cpu_req_i.valid <= 1'b0;
        if (!timed_out) begin
            wait_drain();
        end
        check_memory();
        end_run();
    end

    // APB slave with random wait states
    always @(posedge clk) begin
        if (rst) begin
            apb_rsp_i <= '0;
        end else if (s_psel && s_pen && s_pready) begin
            if (s_pwrite) begin
                mem[s_paddr] = s_pwdata;
            end
            apb_rsp_i.pready <= 1'b0;
        end else if (s_psel && (!s_pen || wait_cnt > 0)) begin
            if (!s_pen) begin
                wait_cnt = {$random(seed)} % 3;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
            if (wait_cnt == 0) begin
                apb_rsp_i.pready <= 1'b1;
                apb_rsp_i.prdata <= mem_read(s_paddr);
            end
        end
    end

    always @(negedge clk) begin
        int idx;
        int a_cyc;
        int a_rd;
        int a_wr;
        addr_t wa;
        cyc++;
        if (!rst) begin
            if (apb_req_o.penable && !apb_req_o.psel) begin
                plain_error("penable high without psel");
            end
            if (apb_req_o.penable && !(s_psel && !(s_pen && s_pready))) begin
                plain_error("penable high without a setup cycle before it");
            end
            // a started transfer holds its address until it completes
            if (s_psel && !(s_pen && s_pready)) begin
                if (!apb_req_o.psel || !apb_req_o.penable) begin
                    plain_error("APB transfer dropped before completion");
                end
                if (apb_req_o.paddr !== s_paddr) begin
                    value_error("paddr", s_paddr, apb_req_o.paddr);
                end
                if (apb_req_o.pwrite !== s_pwrite) begin
                    value_error("pwrite", 32'(s_pwrite), 32'(apb_req_o.pwrite));
                end
            end
            if (apb_req_o.psel && req_ready_o) begin
                plain_error("req_ready_o high while a miss uses the bus");
            end
            if (apb_req_o.psel && apb_req_o.penable && apb_rsp_i.pready) begin
                if (beat == 0) begin
                    burst_base = {apb_req_o.paddr[31:4], 4'b0000};
                end
                if (apb_req_o.paddr !== burst_base + addr_t'(beat * 4)) begin
                    value_error("paddr", burst_base + addr_t'(beat * 4), apb_req_o.paddr);
                end
                beat = (beat + 1) % 4;
                if (apb_req_o.pwrite) begin
                    wr_cnt++;
                    if (apb_req_o.pwdata !== ref_read(apb_req_o.paddr)) begin
                        value_error("pwdata", ref_read(apb_req_o.paddr), apb_req_o.pwdata);
                    end
                end else begin
                    rd_cnt++;
                end
            end
            if (data_ok_o) begin
                if (q_idx.size() == 0) begin
                    plain_error("data_ok_o without an outstanding request");
                end else begin
                    idx = q_idx.pop_front();
                    a_cyc = q_cyc.pop_front();
                    a_rd = q_rd.pop_front();
                    a_wr = q_wr.pop_front();
                    if (t_strb[idx] == '0 && rdata_o !== t_exp[idx]) begin
                        value_error($sformatf("rdata_o[%0d]", idx), t_exp[idx], rdata_o);
                    end
                    // a load hit leaves room for the next request at once
                    if (t_kind[idx] == "h" && t_strb[idx] == '0) begin
                        if (req_ready_o !== 1'b1) begin
                            value_error("req_ready_o", 32'd1, 32'(req_ready_o));
                        end
                    end else if (t_kind[idx] == "m" || t_strb[idx] != '0) begin
                        if (req_ready_o !== 1'b0) begin
                            value_error("req_ready_o", 32'd0, 32'(req_ready_o));
                        end
                    end
                    if (t_kind[idx] == "h") begin
                        if (cyc != a_cyc + 1) begin
                            value_error("data_ok_o cycle", a_cyc + 1, cyc);
                        end
                        if (rd_cnt != a_rd || wr_cnt != a_wr) begin
                            plain_error($sformatf("bus traffic on hit %0d", idx));
                        end
                    end else if (t_kind[idx] == "m") begin
                        if (rd_cnt - a_rd != 4) begin
                            value_error("apb read beats", 4, rd_cnt - a_rd);
                        end
                        if (wr_cnt - a_wr != 0 && wr_cnt - a_wr != 4) begin
                            plain_error($sformatf("partial write-back on miss %0d", idx));
                        end
                    end
                end
            end
            if (cpu_req_i.valid && req_ready_o) begin
                q_idx.push_back(next_idx);
                q_cyc.push_back(cyc);
                q_rd.push_back(rd_cnt);
                q_wr.push_back(wr_cnt);
                if (t_strb[next_idx] != '0) begin
                    wa = {t_addr[next_idx][31:2], 2'b00};
                    ref_mem[wa] = apply_strobes(ref_read(wa), t_wdata[next_idx],
                                                t_strb[next_idx]);
                end
                next_idx++;
            end
        end
        s_ready = req_ready_o;
        s_psel = apb_req_o.psel;
        s_pen = apb_req_o.penable;
        s_pwrite = apb_req_o.pwrite;
        s_paddr = apb_req_o.paddr;
        s_pwdata = apb_req_o.pwdata;
        s_pready = apb_rsp_i.pready;
    end

endmodule

`default_nettype wire

// ==== sim/dcache_trace.txt ====
# op kind addr wdata wstrb expected_load_word
# kind m is a sure miss, h a sure hit, x either
ld m 00001000 00000000 0 5a5a0400
ld h 00001004 00000000 0 5a5a0401
ld h 00001008 00000000 0 5a5a0402
ld h 0000100c 00000000 0 5a5a0403
ld h 00001000 00000000 0 5a5a0400
st h 00001004 000000ab 1 00000000
st h 00001008 12340000 c 00000000
ld h 00001004 00000000 0 5a5a04ab
ld h 00001008 00000000 0 12340402
st m 00005024 cafef00d f 00000000
ld h 00005024 00000000 0 cafef00d
ld h 00005020 00000000 0 5a5a1408
st m 00002014 0000beef 3 00000000
st m 00003018 77000000 8 00000000
st x 0000201c 11111111 f 00000000
st m 00004010 00c0ffee 7 00000000
st x 00003014 22220000 c 00000000
st x 00002010 000000aa 1 00000000
st x 00004014 33333333 f 00000000
ld x 00002014 00000000 0 5a5abeef
ld x 00003018 00000000 0 775a0c06
ld x 0000201c 00000000 0 11111111
ld x 00004010 00000000 0 5ac0ffee
ld x 00003014 00000000 0 22220c05
ld x 00002010 00000000 0 5a5a08aa
ld x 00004014 00000000 0 33333333
ld x 00002018 00000000 0 5a5a0806
ld h 00001004 00000000 0 5a5a04ab
ld h 00005024 00000000 0 cafef00d
ld h 0000100c 00000000 0 5a5a0403

// ==== tb.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_req_stage.sv
logic/dcache_arrays.sv
logic/dcache_miss_ctrl.sv
logic/dcache_apb_master.sv
logic/dcache_top.sv
sim/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module dcache_tb \
    -o dcache_sim --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see sim.log"
exit 1
